// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = obj_engine_tb
FILELIST = obj_engine.f
BUILD    = obj_dir
LOG      = sim.log

.PHONY: lint sim clean

lint:
	$(TOOL) --lint-only --timing -Wno-fatal --top-module $(TOP) -f $(FILELIST)

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	-./$(BUILD)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "Testbench passed" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

// File: logic/obj_draw.sv
`include "obj_settings.svh"

module obj_draw (
    input  logic               clk,
    input  logic               rst,
    obj_draw_if.drawer         drw,
    output obj_pkg::rom_addr_t rom_addr,
    output logic               rom_cs,
    input  obj_pkg::rom_word_t rom_data,
    input  logic               rom_ok,
    output logic               wr_en,
    output obj_pkg::coord_t    wr_x,
    output obj_pkg::color_t    wr_color
);
    import obj_pkg::*;

    typedef enum logic [1:0] {
        DR_IDLE, DR_FETCH, DR_WRITE
    } draw_state_t;

    draw_state_t                   state;
    code_t                         code;
    coord_t                        xpos;
    pal_t                          pal;
    logic                          hflip;
    tile_row_t                     row;
    logic                          half;
    rom_word_t                     left_w;
    rom_word_t                     right_w;
    rom_word_t                     src_word;
    pixel_t                        pixel;
    logic [$clog2(`TILE_SIZE)-1:0] col;
    logic [$clog2(`TILE_SIZE)-1:0] src;

    assign drw.busy = state != DR_IDLE;

    // Only changes while rom_cs is low
    assign rom_addr = {code, row, half};

    // Mirrored column order with H flip
    assign src      = hflip ? ~col : col;
    assign src_word = src[3] ? right_w : left_w;
    assign pixel    = src_word[{src[2:0], 2'b00} +: 4];

    // Transparent pixels leave the buffer alone
    assign wr_en    = (state == DR_WRITE) && (pixel != '0);
    // X wraps modulo 256
    assign wr_x     = xpos + coord_t'(col);
    assign wr_color = {pal, pixel};

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state  <= DR_IDLE;
            rom_cs <= 1'b0;
            half   <= 1'b0;
            col    <= '0;
        end else begin
            case (state)
                DR_IDLE: begin
                    if (drw.draw) begin
                        // Left half first
                        half   <= 1'b0;
                        rom_cs <= 1'b1;
                        state  <= DR_FETCH;
                    end
                end
                DR_FETCH: begin
                    if (!rom_cs) begin
                        // Right half request after the idle cycle
                        rom_cs <= 1'b1;
                    end else if (rom_ok) begin
                        rom_cs <= 1'b0;
                        half   <= 1'b1;
                        if (half) begin
                            col   <= '0;
                            state <= DR_WRITE;
                        end
                    end
                end
                DR_WRITE: begin
                    col <= col + 1'b1;
                    if (col == 4'(`TILE_SIZE - 1)) begin
                        state <= DR_IDLE;
                    end
                end
                default: state <= DR_IDLE;
            endcase
        end
    end

    // Request and ROM data latches
    always_ff @(posedge clk) begin
        if (state == DR_IDLE && drw.draw) begin
            code  <= drw.code;
            xpos  <= drw.xpos;
            pal   <= drw.pal;
            hflip <= drw.hflip;
            // V flip inverts the row
            row   <= drw.vflip ? ~drw.ysub : drw.ysub;
        end
        if (rom_cs && rom_ok) begin
            if (half) begin
                right_w <= rom_data;
            end else begin
                left_w <= rom_data;
            end
        end
    end

endmodule

// File: logic/obj_draw_if.sv
interface obj_draw_if;
    import obj_pkg::*;

    // One-cycle start strobe, only while busy is low
    logic      draw;
    code_t     code;
    coord_t    xpos;
    pal_t      pal;
    logic      hflip;
    logic      vflip;
    // Tile row before vertical flip
    tile_row_t ysub;
    // High from the cycle after draw to the last pixel
    logic      busy;

    modport scan (output draw, code, xpos, pal, hflip, vflip, ysub, input busy);

    modport drawer (input draw, code, xpos, pal, hflip, vflip, ysub, output busy);

endinterface

// File: logic/obj_engine.sv
module obj_engine (
    input  logic               clk,
    input  logic               rst,
    // CPU byte port
    input  obj_pkg::tbl_addr_t cpu_addr,
    input  obj_pkg::coord_t    cpu_din,
    input  logic               cpu_we,
    output obj_pkg::coord_t    cpu_dout,
    // Video timing
    input  logic               hinit,
    input  obj_pkg::coord_t    vrender,
    input  obj_pkg::hpos_t     hdump,
    input  logic               pxl_cen,
    // Graphics ROM
    output obj_pkg::rom_addr_t rom_addr,
    output logic               rom_cs,
    input  obj_pkg::rom_word_t rom_data,
    input  logic               rom_ok,
    // Palette and pixel, 0 means no sprite
    output obj_pkg::color_t    pxl
);
    import obj_pkg::*;

    tbl_addr_t scan_addr;
    coord_t    scan_dout;
    logic      wr_en;
    coord_t    wr_x;
    color_t    wr_color;

    // Scanner to drawer request
    obj_draw_if drw_if ();

    obj_ram u_ram (
        .clk       (clk),
        .cpu_addr  (cpu_addr),
        .cpu_din   (cpu_din),
        .cpu_we    (cpu_we),
        .cpu_dout  (cpu_dout),
        .scan_addr (scan_addr),
        .scan_dout (scan_dout)
    );

    obj_scan u_scan (
        .clk       (clk),
        .rst       (rst),
        .hinit     (hinit),
        .vrender   (vrender),
        .scan_addr (scan_addr),
        .scan_dout (scan_dout),
        .drw       (drw_if.scan)
    );

    obj_draw u_draw (
        .clk      (clk),
        .rst      (rst),
        .drw      (drw_if.drawer),
        .rom_addr (rom_addr),
        .rom_cs   (rom_cs),
        .rom_data (rom_data),
        .rom_ok   (rom_ok),
        .wr_en    (wr_en),
        .wr_x     (wr_x),
        .wr_color (wr_color)
    );

    obj_linebuf u_linebuf (
        .clk      (clk),
        .rst      (rst),
        .hinit    (hinit),
        .pxl_cen  (pxl_cen),
        .hdump    (hdump),
        .wr_en    (wr_en),
        .wr_x     (wr_x),
        .wr_color (wr_color),
        .pxl      (pxl)
    );

endmodule

// File: logic/obj_linebuf.sv
`include "obj_settings.svh"

module obj_linebuf (
    input  logic            clk,
    input  logic            rst,
    input  logic            hinit,
    input  logic            pxl_cen,
    input  obj_pkg::hpos_t  hdump,
    input  logic            wr_en,
    input  obj_pkg::coord_t wr_x,
    input  obj_pkg::color_t wr_color,
    output obj_pkg::color_t pxl
);
    import obj_pkg::*;

    // Two banks, one drawn while the other is shown
    color_t mem [2][`LINE_WIDTH];
    logic   bank;
    logic   hinit_l;
    logic   hinit_edge;
    logic   dr_bank;
    logic   rd_bank;
    logic   visible;
    coord_t rd_x;

    assign hinit_edge = hinit & ~hinit_l;
    // Swapped roles already on the edge cycle
    assign dr_bank    = hinit_edge ? ~bank : bank;
    assign rd_bank    = ~dr_bank;
    assign visible    = hdump < hpos_t'(`LINE_WIDTH);
    assign rd_x       = coord_t'(hdump);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            bank    <= 1'b0;
            hinit_l <= 1'b0;
            pxl     <= '0;
        end else begin
            hinit_l <= hinit;
            if (hinit_edge) begin
                bank <= ~bank;
            end
            // Held until the next pixel enable, zero in blanking
            if (pxl_cen) begin
                pxl <= visible ? mem[rd_bank][rd_x] : '0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[dr_bank][wr_x] <= wr_color;
        end
        // Read and clear, the bank starts empty for its next draw
        if (pxl_cen && visible) begin
            mem[rd_bank][rd_x] <= '0;
        end
    end

endmodule

// File: logic/obj_pkg.sv
`include "obj_settings.svh"

package obj_pkg;

    // Byte address into the object table
    typedef logic [$clog2(`OBJ_COUNT * `OBJ_BYTES)-1:0] tbl_addr_t;
    typedef logic [$clog2(`OBJ_COUNT)-1:0] obj_idx_t;
    // Line number or X position
    typedef logic [7:0] coord_t;
    // Horizontal counter, blanking included
    typedef logic [8:0] hpos_t;
    typedef logic [7:0] code_t;
    typedef logic [3:0] pal_t;
    typedef logic [$clog2(`TILE_SIZE)-1:0] tile_row_t;
    // Zero is transparent
    typedef logic [3:0] pixel_t;
    // Palette in the high nibble
    typedef logic [7:0] color_t;
    // Code, row and half
    typedef logic [12:0] rom_addr_t;
    // Eight pixels, leftmost in the low nibble
    typedef logic [31:0] rom_word_t;

    typedef enum logic [2:0] {
        IDLE, READ_Y, READ_CODE, READ_X, READ_ATTR, ISSUE, WAIT_BUSY
    } scan_state_t;

endpackage

// File: logic/obj_ram.sv
`include "obj_settings.svh"

module obj_ram (
    input  logic               clk,
    input  obj_pkg::tbl_addr_t cpu_addr,
    input  obj_pkg::coord_t    cpu_din,
    input  logic               cpu_we,
    output obj_pkg::coord_t    cpu_dout,
    input  obj_pkg::tbl_addr_t scan_addr,
    output obj_pkg::coord_t    scan_dout
);
    import obj_pkg::*;

    // Four bytes per object, object n at 4n
    coord_t mem [`OBJ_COUNT * `OBJ_BYTES];

    // CPU side, write and read share the address
    always_ff @(posedge clk) begin
        if (cpu_we) begin
            mem[cpu_addr] <= cpu_din;
        end
        // Old data on a write cycle
        cpu_dout <= mem[cpu_addr];
    end

    // Scanner side, read only
    // Data one cycle after the address
    always_ff @(posedge clk) begin
        scan_dout <= mem[scan_addr];
    end

endmodule

// File: logic/obj_scan.sv
`include "obj_settings.svh"

module obj_scan (
    input  logic               clk,
    input  logic               rst,
    input  logic               hinit,
    input  obj_pkg::coord_t    vrender,
    output obj_pkg::tbl_addr_t scan_addr,
    input  obj_pkg::coord_t    scan_dout,
    obj_draw_if.scan           drw
);
    import obj_pkg::*;

    scan_state_t                   state;
    obj_idx_t                      obj_cnt;
    coord_t                        target;
    coord_t                        ydiff;
    logic                          hinit_l;
    logic                          hinit_edge;
    logic                          in_range;
    logic                          last_obj;
    logic [$clog2(`OBJ_BYTES)-1:0] sub;

    assign hinit_edge = hinit & ~hinit_l;
    // Modulo 256, so objects wrap past the bottom
    assign ydiff      = target - scan_dout;
    assign last_obj   = obj_cnt == '0;

    // Byte within the entry follows the state
    // ISSUE keeps the attribute byte on the bus
    always_comb begin
        case (state)
            READ_Y:    sub = 2'd0;
            READ_CODE: sub = 2'd1;
            READ_X:    sub = 2'd2;
            default:   sub = 2'd3;
        endcase
    end

    assign scan_addr = {obj_cnt, sub};

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state    <= IDLE;
            hinit_l  <= 1'b0;
            drw.draw <= 1'b0;
            obj_cnt  <= '0;
            target   <= '0;
            in_range <= 1'b0;
        end else begin
            hinit_l  <= hinit;
            drw.draw <= 1'b0;
            if (hinit_edge) begin
                // Restart from the top object, any pending scan is lost
                target  <= vrender + 8'd1;
                obj_cnt <= obj_idx_t'(`OBJ_COUNT - 1);
                state   <= READ_Y;
            end else begin
                case (state)
                    IDLE: state <= IDLE;
                    // Y address out, data next cycle
                    READ_Y: state <= READ_CODE;
                    READ_CODE: begin
                        in_range <= ydiff < coord_t'(`TILE_SIZE);
                        state    <= READ_X;
                    end
                    READ_X:    state <= READ_ATTR;
                    READ_ATTR: state <= ISSUE;
                    ISSUE: begin
                        if (!in_range) begin
                            // Skip, no request
                            obj_cnt <= obj_cnt - 1'b1;
                            state   <= last_obj ? IDLE : READ_Y;
                        end else if (!drw.busy) begin
                            drw.draw <= 1'b1;
                            state    <= WAIT_BUSY;
                        end
                    end
                    // Busy rises here
                    WAIT_BUSY: begin
                        obj_cnt <= obj_cnt - 1'b1;
                        state   <= last_obj ? IDLE : READ_Y;
                    end
                    default: state <= IDLE;
                endcase
            end
        end
    end

    // Request fields, captured as the bytes arrive
    always_ff @(posedge clk) begin
        case (state)
            READ_CODE: drw.ysub <= tile_row_t'(ydiff);
            READ_X:    drw.code <= scan_dout;
            READ_ATTR: drw.xpos <= scan_dout;
            ISSUE: begin
                // Attribute byte: palette, H flip bit 6, V flip bit 7
                drw.pal   <= pal_t'(scan_dout[3:0]);
                drw.hflip <= scan_dout[6];
                drw.vflip <= scan_dout[7];
            end
            default: ;
        endcase
    end

endmodule

// File: logic/obj_settings.svh
`ifndef OBJ_SETTINGS_SVH
`define OBJ_SETTINGS_SVH

// Object table geometry
// Entries in the table
`define OBJ_COUNT 32
// Bytes per entry: Y, code, X, attribute
`define OBJ_BYTES 4

// Visible pixels per line, one line buffer bank
`define LINE_WIDTH 256

// Square sprite tiles
`define TILE_SIZE 16

`endif

// File: obj_engine.f
+incdir+logic
logic/obj_pkg.sv
logic/obj_draw_if.sv
logic/obj_ram.sv
logic/obj_scan.sv
logic/obj_draw.sv
logic/obj_linebuf.sv
logic/obj_engine.sv
verif/obj_engine_properties.sv
verif/obj_engine_tb.sv

// File: verif/obj_engine_properties.sv
module obj_engine_properties (
    input logic               clk,
    input logic               rst,
    input logic               draw,
    input logic               busy,
    input logic               rom_cs,
    input logic               rom_ok,
    input obj_pkg::rom_addr_t rom_addr,
    input logic               wr_en
);

    // Scanner starts the drawer only while it is idle
    draw_while_idle: assert property (
        @(posedge clk) disable iff (rst) draw |-> !busy
    ) else $error("draw strobe while the drawer is busy");

    // Address held for the whole ROM request
    rom_addr_held: assert property (
        @(posedge clk) disable iff (rst) (rom_cs && !rom_ok) |=> $stable(rom_addr)
    ) else $error("rom_addr changed during a pending ROM request");

    // Pixel writes belong to a draw in progress and never overlap a ROM request
    write_in_busy: assert property (
        @(posedge clk) disable iff (rst) wr_en |-> busy && !rom_cs
    ) else $error("line buffer write outside a draw");

endmodule

bind obj_engine obj_engine_properties u_props (
    .clk      (clk),
    .rst      (rst),
    .draw     (drw_if.draw),
    .busy     (drw_if.busy),
    .rom_cs   (rom_cs),
    .rom_ok   (rom_ok),
    .rom_addr (rom_addr),
    .wr_en    (wr_en)
);

// File: verif/obj_engine_tb.sv
`include "obj_settings.svh"

module obj_engine_tb;
    import obj_pkg::*;

    localparam int NUM_ROWS      = 6;
    localparam int NUM_OBJS      = 16;
    localparam int LINE_TIMEOUT  = 4096;
    localparam int PIXEL_TIMEOUT = 16;
    localparam int TBL_SIZE      = `OBJ_COUNT * `OBJ_BYTES;

    logic      clk;
    logic      rst;
    tbl_addr_t cpu_addr;
    coord_t    cpu_din;
    logic      cpu_we;
    coord_t    cpu_dout;
    logic      hinit;
    coord_t    vrender;
    hpos_t     hdump;
    logic      pxl_cen;
    rom_addr_t rom_addr;
    logic      rom_cs;
    rom_word_t rom_data;
    logic      rom_ok;
    color_t    pxl;

    // Table contents as last written by the CPU
    coord_t tbl [TBL_SIZE];
    // Reference line for the row under test
    color_t expected [`LINE_WIDTH];

    coord_t row_line [NUM_ROWS] = '{8'h40, 8'h05, 8'h80, 8'h20, 8'h90, 8'h60};
    string  row_desc [NUM_ROWS] = '{
        "rows 0 and 15 and both neighbors", "Y and X wrap", "flips",
        "priority and transparency", "busy line", "empty line after busy line"
    };
    // Each entry holds row, object index, Y, code, X and attribute
    logic [47:0] objs [NUM_OBJS] = '{
        48'h00_05_41_10_10_01, 48'h00_06_40_11_40_02,
        48'h00_07_31_12_70_03, 48'h00_08_30_13_a0_04,
        48'h01_00_f8_21_f8_05, 48'h01_1f_05_22_30_0f,
        48'h02_03_7a_31_20_45, 48'h02_04_7a_31_50_86,
        48'h02_09_75_32_90_c7, 48'h03_14_12_41_44_03,
        48'h03_02_1c_42_48_02, 48'h03_01_18_43_40_01,
        48'h04_0a_88_51_00_08, 48'h04_0b_84_52_08_49,
        48'h04_0c_8f_53_f0_8a, 48'h04_0d_81_54_80_cb
    };

    obj_engine dut (
        .clk      (clk),
        .rst      (rst),
        .cpu_addr (cpu_addr),
        .cpu_din  (cpu_din),
        .cpu_we   (cpu_we),
        .cpu_dout (cpu_dout),
        .hinit    (hinit),
        .vrender  (vrender),
        .hdump    (hdump),
        .pxl_cen  (pxl_cen),
        .rom_addr (rom_addr),
        .rom_cs   (rom_cs),
        .rom_data (rom_data),
        .rom_ok   (rom_ok),
        .pxl      (pxl)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Fixed tile graphics with half the nibbles kept small so zeros are common
    function automatic rom_word_t rom_word(input rom_addr_t a);
        rom_word_t w;
        w = 32'(a) * 32'h9e37_79b1 ^ {a, 19'h2b5a3};
        w = w ^ (w >> 13);
        return w & 32'h3f3f_f3f3;
    endfunction

    task automatic fail_now(input string msg);
        $display("%s", msg);
        $display("Testbench failed");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_color(input string what, input color_t got, input color_t exp);
        if (got !== exp) begin
            fail_now($sformatf("[FAIL] pxl %s: got %h, expected %h", what, got, exp));
        end
    endtask

    task automatic check_byte(input string what, input coord_t got, input coord_t exp);
        if (got !== exp) begin
            fail_now($sformatf("[FAIL] cpu_dout %s: got %h, expected %h", what, got, exp));
        end
    endtask

    // Returns on the edge where the DUT sees the line start
    task automatic wait_hinit();
        int   n;
        logic seen;
        n    = 0;
        seen = 1'b0;
        while (!seen && n < LINE_TIMEOUT) begin
            @(posedge clk);
            seen = hinit;
            n++;
        end
        if (!seen) begin
            fail_now("Timed out waiting for the line start pulse");
        end
    endtask

    task automatic wait_pixel(input hpos_t h);
        int   n;
        logic seen;
        n    = 0;
        seen = 1'b0;
        while (!seen && n < PIXEL_TIMEOUT) begin
            @(posedge clk);
            seen = pxl_cen && hdump == h;
            n++;
        end
        if (!seen) begin
            fail_now($sformatf("Timed out waiting for pixel enable at hdump %0d", h));
        end
    endtask

    // Unused entries parked half a screen away from the line
    task automatic load_table(input int r, input coord_t line);
        int base;
        for (int o = 0; o < `OBJ_COUNT; o++) begin
            tbl[o * 4]     = line + 8'h80;
            tbl[o * 4 + 1] = 8'(o);
            tbl[o * 4 + 2] = 8'(o * 8);
            tbl[o * 4 + 3] = 8'hcf;
        end
        for (int i = 0; i < NUM_OBJS; i++) begin
            if (int'(objs[i][47:40]) == r) begin
                base              = int'(objs[i][39:32]) * 4;
                tbl[base]         = objs[i][31:24];
                tbl[base + 1]     = objs[i][23:16];
                tbl[base + 2]     = objs[i][15:8];
                tbl[base + 3]     = objs[i][7:0];
            end
        end
        for (int b = 0; b < TBL_SIZE; b++) begin
            @(posedge clk);
            cpu_we   <= 1'b1;
            cpu_addr <= tbl_addr_t'(b);
            cpu_din  <= tbl[b];
        end
        @(posedge clk);
        cpu_we <= 1'b0;
    endtask

    // Data arrives one edge after the address
    task automatic read_table();
        for (int b = 0; b < TBL_SIZE; b++) begin
            @(posedge clk);
            cpu_addr <= tbl_addr_t'(b);
            @(posedge clk);
            @(negedge clk);
            check_byte($sformatf("at address %0d", b), cpu_dout, tbl[b]);
        end
    endtask

    // Objects 31 down to 0 so later ones land on top
    task automatic build_expected(input coord_t line);
        coord_t    y;
        code_t     code;
        coord_t    x;
        coord_t    attr;
        coord_t    diff;
        tile_row_t row;
        int        src;
        rom_word_t w;
        pixel_t    pix;
        for (int i = 0; i < `LINE_WIDTH; i++) begin
            expected[i] = '0;
        end
        for (int o = `OBJ_COUNT - 1; o >= 0; o--) begin
            y    = tbl[o * 4];
            code = tbl[o * 4 + 1];
            x    = tbl[o * 4 + 2];
            attr = tbl[o * 4 + 3];
            diff = line - y;
            if (diff < `TILE_SIZE) begin
                row = attr[7] ? tile_row_t'(`TILE_SIZE - 1 - diff) : tile_row_t'(diff);
                for (int c = 0; c < `TILE_SIZE; c++) begin
                    src = attr[6] ? `TILE_SIZE - 1 - c : c;
                    w   = rom_word({code, row, src >= 8});
                    pix = w[(src % 8) * 4 +: 4];
                    if (pix != '0) begin
                        expected[coord_t'(x + c)] = {attr[3:0], pix};
                    end
                end
            end
        end
    endtask

    task automatic check_line(input int r);
        wait_hinit();
        for (int h = 0; h < `LINE_WIDTH; h++) begin
            if (h != 0) begin
                wait_pixel(hpos_t'(h));
            end
            @(negedge clk);
            check_color($sformatf("at x=%0d, %s", h, row_desc[r]), pxl, expected[h]);
        end
        // First blanking pixel
        wait_pixel(hpos_t'(`LINE_WIDTH));
        @(negedge clk);
        check_color($sformatf("in blanking, %s", row_desc[r]), pxl, '0);
    endtask

    // One pixel every four clocks with the line start at hdump 0
    initial begin : video_timing
        hpos_t      h;
        logic [1:0] phase;
        h       = '0;
        phase   = '0;
        hinit   = 1'b0;
        hdump   = '0;
        pxl_cen = 1'b0;
        forever begin
            @(posedge clk);
            pxl_cen <= phase == 2'd0;
            hinit   <= phase == 2'd0 && h == '0;
            hdump   <= h;
            phase = phase + 2'd1;
            if (phase == 2'd0) begin
                h = h + 9'd1;
            end
        end
    end

    // Graphics ROM with 1 to 3 cycles of latency
    initial begin : rom_model
        int wait_cnt;
        wait_cnt = 0;
        rom_ok   = 1'b0;
        rom_data = '0;
        void'($urandom(32'h63e39398));
        forever begin
            @(posedge clk);
            if (rom_ok) begin
                rom_ok <= 1'b0;
            end else if (rom_cs) begin
                if (wait_cnt == 0) begin
                    wait_cnt = 1 + int'($urandom % 3);
                end
                wait_cnt--;
                if (wait_cnt == 0) begin
                    rom_ok   <= 1'b1;
                    rom_data <= rom_word(rom_addr);
                end
            end
        end
    end

    initial begin
        rst      = 1'b1;
        cpu_addr = '0;
        cpu_din  = '0;
        cpu_we   = 1'b0;
        vrender  = '0;
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        // Two full lines clear both banks before the first draw
        load_table(-1, row_line[0]);
        wait_hinit();
        wait_hinit();
        for (int r = 0; r < NUM_ROWS; r++) begin
            load_table(r, row_line[r]);
            read_table();
            build_expected(row_line[r]);
            @(posedge clk);
            vrender <= row_line[r] - 8'd1;
            // Drawn during this line and shown during the next
            wait_hinit();
            check_line(r);
        end
        $display("Testbench passed");
        $finish;
    end

endmodule
